// File: ps2_pkg.sv
`default_nettype none

package ps2_pkg;

	typedef logic [7:0] scan_code_t;        // Raw set 2 code byte

	typedef struct packed {
		logic       extended;               // E0 prefix seen
		scan_code_t code;
	} scan_key_t;

	////////////////////
	// Modifier keys

	localparam scan_key_t SC_LSHIFT = '{extended: 1'b0, code: 8'h12};
	localparam scan_key_t SC_RSHIFT = '{extended: 1'b0, code: 8'h59};
	localparam scan_key_t SC_CTRL   = '{extended: 1'b0, code: 8'h14}; // Right ctrl adds E0
	localparam scan_key_t SC_CAPS   = '{extended: 1'b0, code: 8'h58};

	////////////////////
	// Helpers

	// Join the prefix flag and the code byte into one lookup key
	function automatic scan_key_t make_key(input logic extended, input scan_code_t code);
		scan_key_t k;
		k.extended = extended;
		k.code     = code;
		return k;
	endfunction

	function automatic logic is_shift(input scan_key_t k);
		return (k == SC_LSHIFT) || (k == SC_RSHIFT);
	endfunction

	// Either ctrl key, prefix ignored
	function automatic logic is_ctrl(input scan_key_t k);
		return k.code == SC_CTRL.code;
	endfunction

endpackage

`default_nettype wire

// File: abc80_key_pkg.sv
`default_nettype none

package abc80_key_pkg;

	typedef logic [6:0]  key_char_t;        // Code seen on PIO port A
	typedef logic [23:0] timer_t;

	typedef struct packed {
		logic shift;                        // Either shift key down
		logic ctrl;                         // Either ctrl key down
		logic upcase;                       // Caps lock toggle
	} key_mods_t;

	////////////////////
	// Key timing in CLK12 cycles

	localparam timer_t KEYDOWN_CYCLES      = 24'd300_000;   // 25 ms strobe
	localparam timer_t REPEAT_DELAY_CYCLES = 24'd2_000_000; // First repeat
	localparam timer_t REPEAT_RATE_CYCLES  = 24'd500_000;   // Later repeats

	////////////////////
	// Letter case

	localparam int CASE_BIT = 5;            // Set for lower case

	// Mask OR-ed into letters and national keys
	// Lower case when shift and caps lock agree
	function automatic key_char_t case_mask(input key_mods_t m);
		key_char_t mask;
		mask = '0;
		mask[CASE_BIT] = (m.shift == m.upcase);
		return mask;
	endfunction

endpackage

`default_nettype wire

// File: kbd_scan_if.sv
`default_nettype none

interface kbd_scan_if;

	logic                strobe;            // One cycle per event
	logic                pressed;           // Make when high, break when low
	logic                extended;          // E0 prefix seen
	ps2_pkg::scan_code_t code;

	modport src (
		output strobe, pressed, extended, code
	);

	modport dst (
		input strobe, pressed, extended, code
	);

endinterface

`default_nettype wire

// File: kbd_modifiers.sv
`default_nettype none

module kbd_modifiers (
	input  logic                     CLK12,
	input  logic                     RESET,
	kbd_scan_if.dst                  scan,
	output abc80_key_pkg::key_mods_t mods
);

	ps2_pkg::scan_key_t key;
	logic               caps_make;

	assign key       = ps2_pkg::make_key(scan.extended, scan.code);
	assign caps_make = scan.strobe && scan.pressed && (key == ps2_pkg::SC_CAPS);

	////////////////////
	// Modifier state

	always_ff @(posedge CLK12) begin
		if (RESET) begin
			mods <= '0;
		end else if (scan.strobe) begin
			if (ps2_pkg::is_shift(key))
				mods.shift <= scan.pressed;    // Follows make and break
			if (ps2_pkg::is_ctrl(key))
				mods.ctrl <= scan.pressed;
			if (caps_make)
				mods.upcase <= ~mods.upcase;   // Break is ignored
		end
	end

	////////////////////
	// Checks

	// Caps lock is the only source of an upcase change
	upcase_from_caps: assert property (
		@(posedge CLK12) disable iff (RESET)
		$changed(mods.upcase) |-> $past(caps_make || RESET)
	);

endmodule

`default_nettype wire

// File: kbd_translate.sv
`default_nettype none

module kbd_translate (
	input  logic                     CLK12,
	input  logic                     RESET,
	kbd_scan_if.dst                  scan,
	input  abc80_key_pkg::key_mods_t mods,
	output logic                     held,
	output abc80_key_pkg::key_char_t key_char
);

	ps2_pkg::scan_key_t       key;
	abc80_key_pkg::key_char_t alpha;
	abc80_key_pkg::key_char_t next_char;
	logic                     hit;

	assign key   = ps2_pkg::make_key(scan.extended, scan.code);
	assign alpha = abc80_key_pkg::case_mask(mods);

	// Lookup on {ctrl, shift, extended, code}
	always_comb begin
		hit       = 1'b1;
		next_char = '0;
		casez ({mods.ctrl, mods.shift, key})
			////////////////////
			// Ctrl combinations
			{2'b10, 9'h021}: next_char = 7'h03;           // Ctrl C
			{2'b10, 9'h022}: next_char = 7'h18;           // Ctrl X
			{2'b1?, 9'h00E}: next_char = 7'h7F;           // Ctrl backquote

			////////////////////
			// Letters
			{2'b0?, 9'h01C}: next_char = 7'h41 | alpha;   // A
			{2'b0?, 9'h032}: next_char = 7'h42 | alpha;   // B
			{2'b0?, 9'h021}: next_char = 7'h43 | alpha;   // C
			{2'b0?, 9'h023}: next_char = 7'h44 | alpha;   // D
			{2'b0?, 9'h024}: next_char = 7'h45 | alpha;   // E
			{2'b0?, 9'h02B}: next_char = 7'h46 | alpha;   // F
			{2'b0?, 9'h034}: next_char = 7'h47 | alpha;   // G
			{2'b0?, 9'h033}: next_char = 7'h48 | alpha;   // H
			{2'b0?, 9'h043}: next_char = 7'h49 | alpha;   // I
			{2'b0?, 9'h03B}: next_char = 7'h4A | alpha;   // J
			{2'b0?, 9'h042}: next_char = 7'h4B | alpha;   // K
			{2'b0?, 9'h04B}: next_char = 7'h4C | alpha;   // L
			{2'b0?, 9'h03A}: next_char = 7'h4D | alpha;   // M
			{2'b0?, 9'h031}: next_char = 7'h4E | alpha;   // N
			{2'b0?, 9'h044}: next_char = 7'h4F | alpha;   // O
			{2'b0?, 9'h04D}: next_char = 7'h50 | alpha;   // P
			{2'b0?, 9'h015}: next_char = 7'h51 | alpha;   // Q
			{2'b0?, 9'h02D}: next_char = 7'h52 | alpha;   // R
			{2'b0?, 9'h01B}: next_char = 7'h53 | alpha;   // S
			{2'b0?, 9'h02C}: next_char = 7'h54 | alpha;   // T
			{2'b0?, 9'h03C}: next_char = 7'h55 | alpha;   // U
			{2'b0?, 9'h02A}: next_char = 7'h56 | alpha;   // V
			{2'b0?, 9'h01D}: next_char = 7'h57 | alpha;   // W
			{2'b0?, 9'h022}: next_char = 7'h58 | alpha;   // X
			{2'b0?, 9'h035}: next_char = 7'h59 | alpha;   // Y
			{2'b0?, 9'h01A}: next_char = 7'h5A | alpha;   // Z

			////////////////////
			// Digit row
			{2'b00, 9'h016}: next_char = 7'h31;           // 1
			{2'b00, 9'h01E}: next_char = 7'h32;           // 2
			{2'b00, 9'h026}: next_char = 7'h33;           // 3
			{2'b00, 9'h025}: next_char = 7'h34;           // 4
			{2'b00, 9'h02E}: next_char = 7'h35;           // 5
			{2'b00, 9'h036}: next_char = 7'h36;           // 6
			{2'b00, 9'h03D}: next_char = 7'h37;           // 7
			{2'b00, 9'h03E}: next_char = 7'h38;           // 8
			{2'b00, 9'h046}: next_char = 7'h39;           // 9
			{2'b00, 9'h045}: next_char = 7'h30;           // 0

			// Keypad digits, no shifted form
			{2'b00, 9'h069}: next_char = 7'h31;
			{2'b00, 9'h072}: next_char = 7'h32;
			{2'b00, 9'h07A}: next_char = 7'h33;
			{2'b00, 9'h06B}: next_char = 7'h34;
			{2'b00, 9'h073}: next_char = 7'h35;
			{2'b00, 9'h074}: next_char = 7'h36;
			{2'b00, 9'h06C}: next_char = 7'h37;
			{2'b00, 9'h075}: next_char = 7'h38;
			{2'b00, 9'h07D}: next_char = 7'h39;
			{2'b00, 9'h070}: next_char = 7'h30;

			{2'b01, 9'h016}: next_char = 7'h21;           // !
			{2'b01, 9'h01E}: next_char = 7'h22;           // Double quote
			{2'b01, 9'h026}: next_char = 7'h23;           // #
			{2'b01, 9'h025}: next_char = 7'h24;           // Currency sign
			{2'b01, 9'h02E}: next_char = 7'h25;           // %
			{2'b01, 9'h036}: next_char = 7'h26;           // &
			{2'b01, 9'h03D}: next_char = 7'h27;           // Apostrophe
			{2'b01, 9'h03E}: next_char = 7'h28;           // (
			{2'b01, 9'h046}: next_char = 7'h29;           // )
			{2'b01, 9'h045}: next_char = 7'h3D;           // =

			////////////////////
			// Editing keys
			{2'b00, 9'h?5A}: next_char = 7'h0D;           // Enter, both
			{2'b00, 9'h029}: next_char = 7'h20;           // Space
			{2'b00, 9'h16B}: next_char = 7'h08;           // Left arrow
			{2'b00, 9'h066}: next_char = 7'h08;           // Backspace
			{2'b00, 9'h174}: next_char = 7'h09;           // Right arrow

			////////////////////
			// Punctuation
			{2'b00, 9'h041}: next_char = 7'h2C;           // Comma
			{2'b00, 9'h049}: next_char = 7'h2E;           // Period
			{2'b00, 9'h04A}: next_char = 7'h2D;           // Minus
			{2'b00, 9'h04E}: next_char = 7'h2B;           // Plus
			{2'b00, 9'h05D}: next_char = 7'h27;           // Apostrophe
			{2'b00, 9'h00E}: next_char = 7'h3C;           // Less than
			{2'b01, 9'h041}: next_char = 7'h3B;           // Semicolon
			{2'b01, 9'h049}: next_char = 7'h3A;           // Colon
			{2'b01, 9'h04A}: next_char = 7'h5F;           // Underscore
			{2'b01, 9'h04E}: next_char = 7'h3F;           // Question mark
			{2'b01, 9'h05D}: next_char = 7'h2A;           // Asterisk
			{2'b01, 9'h00E}: next_char = 7'h3E;           // Greater than

			// National keys follow the letter case rule
			{2'b0?, 9'h055}: next_char = 7'h40 | alpha;   // E acute
			{2'b0?, 9'h054}: next_char = 7'h5D | alpha;
			{2'b0?, 9'h05B}: next_char = 7'h5E | alpha;
			{2'b0?, 9'h04C}: next_char = 7'h5C | alpha;
			{2'b0?, 9'h052}: next_char = 7'h5B | alpha;

			default:         hit = 1'b0;                  // Not a character key
		endcase
	end

	always_ff @(posedge CLK12) begin
		if (RESET) begin
			held     <= 1'b0;
			key_char <= '0;
		end else if (scan.strobe && hit) begin
			held     <= scan.pressed;
			key_char <= next_char;                    // Break also reloads the code
		end
	end

endmodule

`default_nettype wire

// File: key_repeat.sv
`default_nettype none

module key_repeat (
	input  logic CLK12,
	input  logic RESET,
	input  logic held,
	output logic key_down
);

	abc80_key_pkg::timer_t pulse_cnt;          // Remaining strobe length
	abc80_key_pkg::timer_t repeat_cnt;         // Time to next repeat
	logic                  held_d;
	logic                  held_rise;

	assign held_rise = held && !held_d;

	////////////////////
	// Strobe and repeat timers

	always_ff @(posedge CLK12) begin
		if (RESET) begin
			held_d     <= 1'b0;
			key_down   <= 1'b0;
			pulse_cnt  <= '0;
			repeat_cnt <= '0;
		end else begin
			held_d <= held;

			if (|pulse_cnt)
				pulse_cnt <= pulse_cnt - 1'b1;
			else
				key_down <= 1'b0;                 // Pulse done

			if (held_rise) begin
				key_down   <= 1'b1;
				pulse_cnt  <= abc80_key_pkg::KEYDOWN_CYCLES;
				repeat_cnt <= abc80_key_pkg::REPEAT_DELAY_CYCLES;
			end else if (|repeat_cnt) begin
				repeat_cnt <= repeat_cnt - 1'b1;
			end else if (held) begin
				// Still down after the delay
				key_down   <= 1'b1;
				pulse_cnt  <= abc80_key_pkg::KEYDOWN_CYCLES;
				repeat_cnt <= abc80_key_pkg::REPEAT_RATE_CYCLES;
			end
		end
	end

	////////////////////
	// Checks

	// A pulse is never cut short
	pulse_runs_out: assert property (
		@(posedge CLK12) disable iff (RESET)
		$fell(key_down) |-> $past(pulse_cnt == '0 || RESET)
	);

endmodule

`default_nettype wire

// File: abc80_keyboard.sv
`default_nettype none

module abc80_keyboard (
	input  logic                     CLK12,
	input  logic                     RESET,
	input  logic                     key_strobe,
	input  logic                     key_pressed,
	input  logic                     key_extended,
	input  ps2_pkg::scan_code_t      key_code,     // PS/2 set 2 code
	output abc80_key_pkg::key_char_t key_char,     // To PIO port A bits 6..0
	output logic                     key_down,     // To PIO port A bit 7
	output logic                     upcase
);

	kbd_scan_if               scan ();
	abc80_key_pkg::key_mods_t mods;
	logic                     held;

	// Decoded PS/2 event onto the scan bus
	assign scan.strobe   = key_strobe;
	assign scan.pressed  = key_pressed;
	assign scan.extended = key_extended;
	assign scan.code     = key_code;

	assign upcase = mods.upcase;

	kbd_modifiers u_mods (
		.CLK12 (CLK12),
		.RESET (RESET),
		.scan  (scan),
		.mods  (mods)
	);

	kbd_translate u_translate (
		.CLK12    (CLK12),
		.RESET    (RESET),
		.scan     (scan),
		.mods     (mods),
		.held     (held),
		.key_char (key_char)
	);

	key_repeat u_repeat (
		.CLK12    (CLK12),
		.RESET    (RESET),
		.held     (held),
		.key_down (key_down)
	);

endmodule

`default_nettype wire

// File: tb_key_table.svh
`ifndef TB_KEY_TABLE_SVH
`define TB_KEY_TABLE_SVH

// Columns: name, extended flag, scan code, pressed, modifiers {shift, ctrl, caps on}, expected char
// The caps column is the caps lock state wanted for the row, not a key press

localparam logic [2:0] mod_none  = 3'b000;
localparam logic [2:0] mod_shift = 3'b100;
localparam logic [2:0] mod_ctrl  = 3'b010;
localparam logic [2:0] mod_caps  = 3'b001;
localparam logic [2:0] mod_both  = 3'b101;   // Shift with caps lock on

string                    row_name[$];
ps2_pkg::scan_key_t       row_key[$];
logic                     row_pressed[$];
logic [2:0]               row_mods[$];
abc80_key_pkg::key_char_t row_expect[$];

task automatic add_row(input string name, input logic extended, input ps2_pkg::scan_code_t code,
	input logic pressed, input logic [2:0] mods, input abc80_key_pkg::key_char_t expected);
	ps2_pkg::scan_key_t k;
	k.extended = extended;
	k.code     = code;
	row_name.push_back(name);
	row_key.push_back(k);
	row_pressed.push_back(pressed);
	row_mods.push_back(mods);
	row_expect.push_back(expected);
endtask

task automatic load_key_table();
	// Lower case when shift and caps lock agree
	add_row("a plain",        1'b0, 8'h1C, 1'b1, mod_none,  7'h61);
	add_row("a shift",        1'b0, 8'h1C, 1'b1, mod_shift, 7'h41);
	add_row("z plain",        1'b0, 8'h1A, 1'b1, mod_none,  7'h7A);
	add_row("z shift",        1'b0, 8'h1A, 1'b1, mod_shift, 7'h5A);
	add_row("a caps",         1'b0, 8'h1C, 1'b1, mod_caps,  7'h41);
	add_row("z caps",         1'b0, 8'h1A, 1'b1, mod_caps,  7'h5A);
	add_row("a caps shift",   1'b0, 8'h1C, 1'b1, mod_both,  7'h61);
	add_row("z caps shift",   1'b0, 8'h1A, 1'b1, mod_both,  7'h7A);
	add_row("a break",        1'b0, 8'h1C, 1'b0, mod_none,  7'h61);   // Caps back off
	add_row("digit 1",        1'b0, 8'h16, 1'b1, mod_none,  7'h31);
	add_row("digit 1 shift",  1'b0, 8'h16, 1'b1, mod_shift, 7'h21);
	add_row("digit 0",        1'b0, 8'h45, 1'b1, mod_none,  7'h30);
	add_row("digit 0 shift",  1'b0, 8'h45, 1'b1, mod_shift, 7'h3D);
	add_row("comma",          1'b0, 8'h41, 1'b1, mod_none,  7'h2C);
	add_row("comma shift",    1'b0, 8'h41, 1'b1, mod_shift, 7'h3B);
	add_row("minus",          1'b0, 8'h4A, 1'b1, mod_none,  7'h2D);
	add_row("minus shift",    1'b0, 8'h4A, 1'b1, mod_shift, 7'h5F);
	add_row("keypad 1",       1'b0, 8'h69, 1'b1, mod_none,  7'h31);
	add_row("keypad 0",       1'b0, 8'h70, 1'b1, mod_none,  7'h30);
	add_row("enter",          1'b0, 8'h5A, 1'b1, mod_none,  7'h0D);
	add_row("keypad enter",   1'b1, 8'h5A, 1'b1, mod_none,  7'h0D);
	add_row("left arrow",     1'b1, 8'h6B, 1'b1, mod_none,  7'h08);
	add_row("right arrow",    1'b1, 8'h74, 1'b1, mod_none,  7'h09);
	add_row("space",          1'b0, 8'h29, 1'b1, mod_none,  7'h20);
	add_row("ctrl c",         1'b0, 8'h21, 1'b1, mod_ctrl,  7'h03);
	add_row("ctrl x",         1'b0, 8'h22, 1'b1, mod_ctrl,  7'h18);
	add_row("f12 ignored",    1'b0, 8'h07, 1'b1, mod_none,  7'h18);   // Keeps the last char
	add_row("national",       1'b0, 8'h54, 1'b1, mod_none,  7'h7D);
	add_row("national shift", 1'b0, 8'h54, 1'b1, mod_shift, 7'h5D);
endtask

`endif

// File: tb_abc80_keyboard.sv
`default_nettype none

module tb_abc80_keyboard;

	logic                     CLK12;
	logic                     RESET;
	logic                     key_strobe;
	logic                     key_pressed;
	logic                     key_extended;
	ps2_pkg::scan_code_t      key_code;
	abc80_key_pkg::key_char_t key_char;
	logic                     key_down;
	logic                     upcase;

	int   num_checks;
	int   num_errors;
	logic upcase_model;                        // Caps state the DUT should hold
	logic table_loaded;

	localparam ps2_pkg::scan_key_t space_key = '{extended: 1'b0, code: 8'h29};

	`include "tb_key_table.svh"

	abc80_keyboard uut (
		.CLK12        (CLK12),
		.RESET        (RESET),
		.key_strobe   (key_strobe),
		.key_pressed  (key_pressed),
		.key_extended (key_extended),
		.key_code     (key_code),
		.key_char     (key_char),
		.key_down     (key_down),
		.upcase       (upcase)
	);

	always #50 CLK12 = ~CLK12;

	////////////////////
	// Compare tasks

	task automatic check_char(input string name, input abc80_key_pkg::key_char_t expected,
		input abc80_key_pkg::key_char_t actual);
		num_checks++;
		if (actual !== expected) begin
			num_errors++;
			$display("MISMATCH %s: expected %02h, actual %02h", name, expected, actual);
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		num_checks++;
		if (actual !== expected) begin
			num_errors++;
			$display("MISMATCH %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		num_checks++;
		if (actual != expected) begin
			num_errors++;
			$display("MISMATCH %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	////////////////////
	// Stimulus

	// Called at edge plus 10, returns one edge later with the strobe low
	task automatic send_event(input logic extended, input ps2_pkg::scan_code_t code,
		input logic pressed);
		key_extended = extended;
		key_code     = code;
		key_pressed  = pressed;
		key_strobe   = 1'b1;
		@(posedge CLK12);
		#10;
		key_strobe   = 1'b0;
	endtask

	task automatic send_key(input ps2_pkg::scan_key_t k, input logic pressed);
		send_event(k.extended, k.code, pressed);
	endtask

	task automatic apply_row(input int r);
		logic want_shift;
		logic want_ctrl;
		want_shift = row_mods[r][2];
		want_ctrl  = row_mods[r][1];
		if (row_mods[r][0] != upcase_model) begin
			send_key(ps2_pkg::SC_CAPS, 1'b1);          // Make toggles caps lock
			upcase_model = ~upcase_model;
			check_bit({row_name[r], " upcase"}, upcase_model, upcase);
			send_key(ps2_pkg::SC_CAPS, 1'b0);
		end
		if (want_shift)
			send_key(ps2_pkg::SC_LSHIFT, 1'b1);
		if (want_ctrl)
			send_key(ps2_pkg::SC_CTRL, 1'b1);
		send_key(row_key[r], row_pressed[r]);
		check_char(row_name[r], row_expect[r], key_char);
		if (row_pressed[r])
			send_key(row_key[r], 1'b0);                // Release before the modifiers
		if (want_ctrl)
			send_event(1'b1, ps2_pkg::SC_CTRL.code, 1'b0); // Right ctrl break
		if (want_shift)
			send_key(ps2_pkg::SC_LSHIFT, 1'b0);
	endtask

	task automatic count_rises(input int cycles, output int rises);
		logic prev;
		rises = 0;
		prev  = key_down;
		repeat (cycles) begin
			@(posedge CLK12);
			#10;
			if (key_down && !prev)
				rises++;
			prev = key_down;
		end
	endtask

	////////////////////
	// Main sequence

	initial begin
		int   pulse_len;
		int   rises;
		logic prev;
		CLK12        = 1'b0;
		RESET        = 1'b1;
		key_strobe   = 1'b0;
		key_pressed  = 1'b0;
		key_extended = 1'b0;
		key_code     = '0;
		num_checks   = 0;
		num_errors   = 0;
		upcase_model = 1'b0;
		table_loaded = 1'b0;
		load_key_table();
		table_loaded = 1'b1;

		repeat (4) @(posedge CLK12);
		#10;
		RESET = 1'b0;
		@(posedge CLK12);
		#10;
		check_bit("reset key_down", 1'b0, key_down);
		check_bit("reset upcase", 1'b0, upcase);
		check_char("reset key_char", 7'h00, key_char);

		for (int r = 0; r < row_name.size(); r++)
			apply_row(r);

		while (key_down) begin                     // Last table pulse runs out
			@(posedge CLK12);
			#10;
		end

		// Press and release inside one pulse
		send_key(space_key, 1'b1);
		check_bit("single press before rise", 1'b0, key_down);
		pulse_len = 0;
		rises     = 0;
		prev      = 1'b0;
		for (int i = 0; i < int'(abc80_key_pkg::KEYDOWN_CYCLES) + 1000; i++) begin
			@(posedge CLK12);
			#10;
			key_strobe  = (i == 3);               // Break strobe
			key_pressed = 1'b0;
			if (i == 0)
				check_bit("single press rise", 1'b1, key_down);
			if (key_down)
				pulse_len++;
			if (key_down && !prev)
				rises++;
			prev = key_down;
		end
		check_count("single press pulse length", int'(abc80_key_pkg::KEYDOWN_CYCLES) + 1,
			pulse_len);
		check_count("single press pulses", 1, rises);

		// Held key with auto-repeat
		send_key(space_key, 1'b1);
		count_rises(int'(abc80_key_pkg::REPEAT_DELAY_CYCLES)
			+ 2 * int'(abc80_key_pkg::REPEAT_RATE_CYCLES) + 10, rises);
		check_count("auto repeat rises", 4, rises);
		send_key(space_key, 1'b0);
		count_rises(int'(abc80_key_pkg::REPEAT_RATE_CYCLES) + 10, rises);
		check_count("rises after release", 0, rises);

		$display("%0d checks, %0d errors", num_checks, num_errors);
		if (num_errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	////////////////////
	// Watchdog

	initial begin
		int limit;
		wait (table_loaded);
		limit = row_name.size() * 10 + int'(abc80_key_pkg::REPEAT_DELAY_CYCLES)
			+ 3 * int'(abc80_key_pkg::REPEAT_RATE_CYCLES)
			+ 4 * int'(abc80_key_pkg::KEYDOWN_CYCLES) + 10000;
		repeat (limit) @(posedge CLK12);
		$display("Timeout: the run did not end within %0d clock cycles", limit);
		$display("%0d checks, %0d errors", num_checks, num_errors);
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
+incdir+.
ps2_pkg.sv
abc80_key_pkg.sv
kbd_scan_if.sv
kbd_modifiers.sv
kbd_translate.sv
key_repeat.sv
abc80_keyboard.sv
tb_abc80_keyboard.sv

// File: Makefile
# Verilator simulation of the ABC80 keyboard path

TOP := tb_abc80_keyboard
OBJ := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir $(OBJ) -o $(TOP)
	@out="$$(./$(OBJ)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf $(OBJ)
